// File: verilog/pwr_pkg.sv
// ##########################################################
// Shared constants for the power-gating controller: bus
// widths, register map, response codes, sequencer states
// ##########################################################

package pwr_pkg;

  // Status fields are one byte per flag group
  localparam int MAX_DOMAINS = 8;

  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int RESP_W = 2;

  // Register map
  localparam logic [ADDR_W-1:0] REG_POWER_ON    = 8'h00;
  localparam logic [ADDR_W-1:0] REG_POWER_OFF   = 8'h04;
  localparam logic [ADDR_W-1:0] REG_RETENTIVE   = 8'h08;
  localparam logic [ADDR_W-1:0] REG_STATUS      = 8'h0C;
  localparam logic [ADDR_W-1:0] REG_IRQ_PENDING = 8'h10;
  localparam logic [ADDR_W-1:0] REG_IRQ_ENABLE  = 8'h14;

  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

  // Power-up runs OFF..ON, power-down runs ON..OFF
  typedef enum logic [2:0] {
    OFF     = 3'd0,
    SW_ON   = 3'd1,
    RST_REL = 3'd2,
    ISO_REL = 3'd3,
    ON      = 3'd4,
    ISO_SET = 3'd5,
    RST_SET = 3'd6,
    SW_OFF  = 3'd7
  } seq_state_e;

endpackage

// File: verilog/pwr_dom_if.sv
// ##########################################################
// Per-domain link between register block, sequencer and
// status collector
// ##########################################################

`timescale 1ns/1ns

interface pwr_dom_if;

  // Commands, pulses from the register block
  logic req_on;
  logic req_off;
  // Retention choice for the next power-down
  logic retentive;

  // Sequencer state
  logic busy;
  logic is_on;
  logic err;
  // One cycle at the end of every sequence
  logic done;

  modport ctrl (
    output req_on,
    output req_off,
    output retentive
  );

  modport seq (
    input  req_on,
    input  req_off,
    input  retentive,
    output busy,
    output is_on,
    output err,
    output done
  );

  modport mon (
    input busy,
    input is_on,
    input err,
    input done
  );

endinterface

// File: verilog/pwr_axil_regs.sv
// ##########################################################
// AXI4-Lite register slave: command masks, retention and
// interrupt-enable registers, status readback
// ##########################################################

`timescale 1ns/1ns

module pwr_axil_regs #(
  parameter int NUM_DOMAINS = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  input  logic [pwr_pkg::ADDR_W-1:0]  awaddr_i,
  input  logic                        awvalid_i,
  output logic                        awready_o,
  input  logic [pwr_pkg::DATA_W-1:0]  wdata_i,
  input  logic [pwr_pkg::STRB_W-1:0]  wstrb_i,
  input  logic                        wvalid_i,
  output logic                        wready_o,
  output logic [pwr_pkg::RESP_W-1:0]  bresp_o,
  output logic                        bvalid_o,
  input  logic                        bready_i,
  input  logic [pwr_pkg::ADDR_W-1:0]  araddr_i,
  input  logic                        arvalid_i,
  output logic                        arready_o,
  output logic [pwr_pkg::DATA_W-1:0]  rdata_o,
  output logic [pwr_pkg::RESP_W-1:0]  rresp_o,
  output logic                        rvalid_o,
  input  logic                        rready_i,

  pwr_dom_if.ctrl                     dom [NUM_DOMAINS],

  input  logic [pwr_pkg::DATA_W-1:0]  status_word_i,
  input  logic [NUM_DOMAINS-1:0]      pending_i,
  output logic [NUM_DOMAINS-1:0]      irq_clear_o,
  output logic [NUM_DOMAINS-1:0]      irq_enable_o
);

  import pwr_pkg::*;

  logic                   wr_accept;
  logic                   wr_full;
  logic                   wr_mapped;
  logic [NUM_DOMAINS-1:0] wr_mask;
  logic [NUM_DOMAINS-1:0] req_on_v;
  logic [NUM_DOMAINS-1:0] req_off_v;
  logic                   bvalid_q;
  logic [RESP_W-1:0]      bresp_q;
  logic [NUM_DOMAINS-1:0] retentive_q;
  logic [NUM_DOMAINS-1:0] irq_enable_q;

  logic                   rd_accept;
  logic [DATA_W-1:0]      rd_data;
  logic [RESP_W-1:0]      rd_resp;
  logic                   rvalid_q;
  logic [DATA_W-1:0]      rdata_q;
  logic [RESP_W-1:0]      rresp_q;

  // No new write while a response waits
  assign wr_accept = awvalid_i & wvalid_i & ~bvalid_q;
  assign awready_o = wr_accept;
  assign wready_o  = wr_accept;
  assign wr_full   = (wstrb_i == '1);
  assign wr_mask   = wdata_i[NUM_DOMAINS-1:0];

  assign wr_mapped = (awaddr_i == REG_POWER_ON) || (awaddr_i == REG_POWER_OFF) ||
                     (awaddr_i == REG_RETENTIVE) || (awaddr_i == REG_IRQ_PENDING) ||
                     (awaddr_i == REG_IRQ_ENABLE);

  // Partial writes are acknowledged but have no effect
  always_comb begin
    req_on_v    = '0;
    req_off_v   = '0;
    irq_clear_o = '0;
    if (wr_accept && wr_full) begin
      if (awaddr_i == REG_POWER_ON) req_on_v = wr_mask;
      if (awaddr_i == REG_POWER_OFF) req_off_v = wr_mask;
      if (awaddr_i == REG_IRQ_PENDING) irq_clear_o = wr_mask;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bvalid_q     <= 1'b0;
      retentive_q  <= '0;
      irq_enable_q <= '0;
    end else if (wr_accept) begin
      bvalid_q <= 1'b1;
      if (wr_full && awaddr_i == REG_RETENTIVE) retentive_q <= wr_mask;
      if (wr_full && awaddr_i == REG_IRQ_ENABLE) irq_enable_q <= wr_mask;
    end else if (bready_i) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_accept) bresp_q <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
  end

  // Read side
  assign rd_accept = arvalid_i & ~rvalid_q;
  assign arready_o = rd_accept;

  always_comb begin
    rd_resp = RESP_OKAY;
    case (araddr_i)
      REG_POWER_ON, REG_POWER_OFF: rd_data = '0;
      REG_RETENTIVE:   rd_data = DATA_W'(retentive_q);
      REG_STATUS:      rd_data = status_word_i;
      REG_IRQ_PENDING: rd_data = DATA_W'(pending_i);
      REG_IRQ_ENABLE:  rd_data = DATA_W'(irq_enable_q);
      default: begin
        rd_data = '0;
        rd_resp = RESP_SLVERR;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else if (rd_accept) begin
      rvalid_q <= 1'b1;
    end else if (rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  assign bvalid_o     = bvalid_q;
  assign bresp_o      = bresp_q;
  assign rvalid_o     = rvalid_q;
  assign rdata_o      = rdata_q;
  assign rresp_o      = rresp_q;
  assign irq_enable_o = irq_enable_q;

  for (genvar k = 0; k < NUM_DOMAINS; k++) begin : g_dom
    assign dom[k].req_on    = req_on_v[k];
    assign dom[k].req_off   = req_off_v[k];
    assign dom[k].retentive = retentive_q[k];
  end

endmodule

// File: verilog/pwr_domain_seq.sv
// ##########################################################
// Power-up / power-down sequencer for one switched domain,
// with switch acknowledge timeout
// ##########################################################

`timescale 1ns/1ns

module pwr_domain_seq #(
  parameter int ACK_TIMEOUT = 64
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  pwr_dom_if.seq  dom,
  output logic    switch_o,
  output logic    iso_o,
  output logic    rst_n_o,
  output logic    ret_o,
  input  logic    ack_i
);

  import pwr_pkg::*;

  localparam int CNT_W = $clog2(ACK_TIMEOUT + 1);

  seq_state_e       state_q;
  logic [CNT_W-1:0] cnt_q;
  logic             timeout;
  logic             switch_q;
  logic             iso_q;
  logic             rst_n_q;
  logic             ret_q;
  logic             err_q;
  logic             done_q;

  assign timeout = (cnt_q == CNT_W'(ACK_TIMEOUT - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= OFF;
      cnt_q    <= '0;
      switch_q <= 1'b0;
      iso_q    <= 1'b1;
      rst_n_q  <= 1'b0;
      ret_q    <= 1'b0;
      err_q    <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        OFF: if (dom.req_on) begin
          state_q  <= SW_ON;
          switch_q <= 1'b1;
          err_q    <= 1'b0;
          cnt_q    <= '0;
        end
        SW_ON: begin
          if (ack_i) begin
            // Supply is up, memories leave retention
            state_q <= RST_REL;
            rst_n_q <= 1'b1;
            ret_q   <= 1'b0;
          end else if (timeout) begin
            state_q  <= OFF;
            switch_q <= 1'b0;
            err_q    <= 1'b1;
            done_q   <= 1'b1;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RST_REL: begin
          state_q <= ISO_REL;
          iso_q   <= 1'b0;
        end
        ISO_REL: begin
          state_q <= ON;
          done_q  <= 1'b1;
        end
        ON: if (dom.req_off) begin
          state_q <= ISO_SET;
          iso_q   <= 1'b1;
          ret_q   <= dom.retentive;
        end
        ISO_SET: begin
          state_q <= RST_SET;
          rst_n_q <= 1'b0;
        end
        RST_SET: begin
          state_q  <= SW_OFF;
          switch_q <= 1'b0;
          cnt_q    <= '0;
        end
        SW_OFF: begin
          // Outputs are already in the off state here
          if (!ack_i || timeout) begin
            state_q <= OFF;
            done_q  <= 1'b1;
            err_q   <= ack_i;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= OFF;
      endcase
    end
  end

  assign switch_o = switch_q;
  assign iso_o    = iso_q;
  assign rst_n_o  = rst_n_q;
  assign ret_o    = ret_q;

  assign dom.busy  = (state_q != OFF) && (state_q != ON);
  assign dom.is_on = (state_q == ON);
  assign dom.err   = err_q;
  assign dom.done  = done_q;

endmodule

// File: verilog/pwr_status_agg.sv
// ##########################################################
// Status word packing, sticky pending bits and interrupt
// ##########################################################

`timescale 1ns/1ns

module pwr_status_agg #(
  parameter int NUM_DOMAINS = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  pwr_dom_if.mon                     dom [NUM_DOMAINS],
  input  logic [NUM_DOMAINS-1:0]     irq_clear_i,
  input  logic [NUM_DOMAINS-1:0]     irq_enable_i,
  output logic [pwr_pkg::DATA_W-1:0] status_word_o,
  output logic [NUM_DOMAINS-1:0]     pending_o,
  output logic                       irq_o
);

  import pwr_pkg::*;

  logic [NUM_DOMAINS-1:0] is_on_v;
  logic [NUM_DOMAINS-1:0] busy_v;
  logic [NUM_DOMAINS-1:0] err_v;
  logic [NUM_DOMAINS-1:0] done_v;
  logic [NUM_DOMAINS-1:0] pending_d;
  logic [NUM_DOMAINS-1:0] pending_q;
  logic                   irq_q;

  for (genvar k = 0; k < NUM_DOMAINS; k++) begin : g_dom
    assign is_on_v[k] = dom[k].is_on;
    assign busy_v[k]  = dom[k].busy;
    assign err_v[k]   = dom[k].err;
    assign done_v[k]  = dom[k].done;
  end

  // is_on in 7:0, busy in 15:8, err in 23:16
  assign status_word_o = {{(DATA_W - 3 * MAX_DOMAINS){1'b0}},
                          MAX_DOMAINS'(err_v),
                          MAX_DOMAINS'(busy_v),
                          MAX_DOMAINS'(is_on_v)};

  // A completion in the clear cycle keeps its bit
  assign pending_d = (pending_q & ~irq_clear_i) | done_v;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      irq_q     <= 1'b0;
    end else begin
      pending_q <= pending_d;
      irq_q     <= |(pending_d & irq_enable_i);
    end
  end

  assign pending_o = pending_q;
  assign irq_o     = irq_q;

endmodule

// File: verilog/pwr_ctrl_top.sv
// ##########################################################
// Power-gating controller top: AXI4-Lite registers, domain
// sequencers and status collector
// ##########################################################

`timescale 1ns/1ns

module pwr_ctrl_top #(
  parameter int NUM_DOMAINS = 4,
  parameter int ACK_TIMEOUT = 64
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  input  logic [pwr_pkg::ADDR_W-1:0] awaddr_i,
  input  logic                       awvalid_i,
  output logic                       awready_o,
  input  logic [pwr_pkg::DATA_W-1:0] wdata_i,
  input  logic [pwr_pkg::STRB_W-1:0] wstrb_i,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  output logic [pwr_pkg::RESP_W-1:0] bresp_o,
  output logic                       bvalid_o,
  input  logic                       bready_i,
  input  logic [pwr_pkg::ADDR_W-1:0] araddr_i,
  input  logic                       arvalid_i,
  output logic                       arready_o,
  output logic [pwr_pkg::DATA_W-1:0] rdata_o,
  output logic [pwr_pkg::RESP_W-1:0] rresp_o,
  output logic                       rvalid_o,
  input  logic                       rready_i,

  output logic [NUM_DOMAINS-1:0]     dom_switch_o,
  output logic [NUM_DOMAINS-1:0]     dom_iso_o,
  output logic [NUM_DOMAINS-1:0]     dom_rst_n_o,
  output logic [NUM_DOMAINS-1:0]     dom_ret_o,
  input  logic [NUM_DOMAINS-1:0]     dom_ack_i,
  output logic                       irq_o
);

  import pwr_pkg::*;

  logic [DATA_W-1:0]      status_word;
  logic [NUM_DOMAINS-1:0] pending;
  logic [NUM_DOMAINS-1:0] irq_clear;
  logic [NUM_DOMAINS-1:0] irq_enable;

  pwr_dom_if dom_if [NUM_DOMAINS] ();

  pwr_axil_regs #(
    .NUM_DOMAINS(NUM_DOMAINS)
  ) u_regs (
    .clk_i,
    .rst_n_i,
    .awaddr_i,
    .awvalid_i,
    .awready_o,
    .wdata_i,
    .wstrb_i,
    .wvalid_i,
    .wready_o,
    .bresp_o,
    .bvalid_o,
    .bready_i,
    .araddr_i,
    .arvalid_i,
    .arready_o,
    .rdata_o,
    .rresp_o,
    .rvalid_o,
    .rready_i,
    .dom          (dom_if),
    .status_word_i(status_word),
    .pending_i    (pending),
    .irq_clear_o  (irq_clear),
    .irq_enable_o (irq_enable)
  );

  // One sequencer per switched domain
  for (genvar k = 0; k < NUM_DOMAINS; k++) begin : g_seq
    pwr_domain_seq #(
      .ACK_TIMEOUT(ACK_TIMEOUT)
    ) u_seq (
      .clk_i,
      .rst_n_i,
      .dom     (dom_if[k]),
      .switch_o(dom_switch_o[k]),
      .iso_o   (dom_iso_o[k]),
      .rst_n_o (dom_rst_n_o[k]),
      .ret_o   (dom_ret_o[k]),
      .ack_i   (dom_ack_i[k])
    );
  end

  pwr_status_agg #(
    .NUM_DOMAINS(NUM_DOMAINS)
  ) u_status (
    .clk_i,
    .rst_n_i,
    .dom          (dom_if),
    .irq_clear_i  (irq_clear),
    .irq_enable_i (irq_enable),
    .status_word_o(status_word),
    .pending_o    (pending),
    .irq_o
  );

endmodule

// File: verif/pwr_testharness.sv
// ##########################################################
// Harness: controller instance plus switch-cell models as
// acknowledge delay lines, with a stuck-domain option
// ##########################################################

`timescale 1ns/1ns

module pwr_testharness #(
  parameter int                     NUM_DOMAINS        = 4,
  parameter int                     SWITCH_ACK_LATENCY = 15,
  parameter logic [NUM_DOMAINS-1:0] STUCK_MASK         = '0
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       stuck_i,

  input  logic [pwr_pkg::ADDR_W-1:0] awaddr_i,
  input  logic                       awvalid_i,
  output logic                       awready_o,
  input  logic [pwr_pkg::DATA_W-1:0] wdata_i,
  input  logic [pwr_pkg::STRB_W-1:0] wstrb_i,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  output logic [pwr_pkg::RESP_W-1:0] bresp_o,
  output logic                       bvalid_o,
  input  logic                       bready_i,
  input  logic [pwr_pkg::ADDR_W-1:0] araddr_i,
  input  logic                       arvalid_i,
  output logic                       arready_o,
  output logic [pwr_pkg::DATA_W-1:0] rdata_o,
  output logic [pwr_pkg::RESP_W-1:0] rresp_o,
  output logic                       rvalid_o,
  input  logic                       rready_i,

  output logic [NUM_DOMAINS-1:0]     dom_switch_o,
  output logic [NUM_DOMAINS-1:0]     dom_iso_o,
  output logic [NUM_DOMAINS-1:0]     dom_rst_n_o,
  output logic [NUM_DOMAINS-1:0]     dom_ret_o,
  output logic                       irq_o
);

  logic [NUM_DOMAINS-1:0][SWITCH_ACK_LATENCY-1:0] ack_dly;
  logic [NUM_DOMAINS-1:0]                         ack_out;
  logic [NUM_DOMAINS-1:0]                         dom_ack;

  // Switch cells answer a fixed number of cycles after the switch line
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_dly <= '0;
    end else begin
      for (int k = 0; k < NUM_DOMAINS; k++) begin
        ack_dly[k] <= {ack_dly[k][SWITCH_ACK_LATENCY-2:0], dom_switch_o[k]};
      end
    end
  end

  always_comb begin
    for (int k = 0; k < NUM_DOMAINS; k++) begin
      ack_out[k] = ack_dly[k][SWITCH_ACK_LATENCY-1];
    end
  end

  // A stuck cell never acknowledges
  assign dom_ack = ack_out & ~(stuck_i ? STUCK_MASK : '0);

  pwr_ctrl_top #(
    .NUM_DOMAINS(NUM_DOMAINS)
  ) UUT (
    .*,
    .dom_ack_i(dom_ack)
  );

endmodule

// File: verif/tb_pwr_ctrl.sv
// ##########################################################
// Testbench: clock and reset, AXI4-Lite tasks, stimulus
// table with expected values, checks and report
// ##########################################################

`timescale 1ns/1ns

module tb_pwr_ctrl;

  import pwr_pkg::*;

  localparam int                  NUM_DOMAINS        = 4;
  localparam int                  SWITCH_ACK_LATENCY = 15;
  localparam logic [NUM_DOMAINS-1:0] STUCK_MASK      = 4'b1000;
  localparam int                  AXI_WAIT           = 20;
  localparam int                  IRQ_WAIT           = 300;

  typedef enum {OP_WRITE, OP_READ, OP_IRQ, OP_PINS, OP_STUCK} op_e;

  // One table entry; exp is read data, pin word or irq level
  typedef struct {
    string       name;
    op_e         op;
    logic [7:0]  addr;
    logic [31:0] data;
    logic [31:0] exp;
    logic [1:0]  resp;
  } step_t;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   stuck;
  logic [ADDR_W-1:0]      awaddr;
  logic                   awvalid;
  logic                   awready;
  logic [DATA_W-1:0]      wdata;
  logic [STRB_W-1:0]      wstrb;
  logic                   wvalid;
  logic                   wready;
  logic [RESP_W-1:0]      bresp;
  logic                   bvalid;
  logic                   bready;
  logic [ADDR_W-1:0]      araddr;
  logic                   arvalid;
  logic                   arready;
  logic [DATA_W-1:0]      rdata;
  logic [RESP_W-1:0]      rresp;
  logic                   rvalid;
  logic                   rready;
  logic [NUM_DOMAINS-1:0] dom_switch;
  logic [NUM_DOMAINS-1:0] dom_iso;
  logic [NUM_DOMAINS-1:0] dom_rst_n;
  logic [NUM_DOMAINS-1:0] dom_ret;
  logic                   irq;

  step_t steps [64];
  int    n_steps;
  int    n_pass;
  int    n_fail;

  pwr_testharness #(
    .NUM_DOMAINS       (NUM_DOMAINS),
    .SWITCH_ACK_LATENCY(SWITCH_ACK_LATENCY),
    .STUCK_MASK        (STUCK_MASK)
  ) u_harness (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .stuck_i     (stuck),
    .awaddr_i    (awaddr),
    .awvalid_i   (awvalid),
    .awready_o   (awready),
    .wdata_i     (wdata),
    .wstrb_i     (wstrb),
    .wvalid_i    (wvalid),
    .wready_o    (wready),
    .bresp_o     (bresp),
    .bvalid_o    (bvalid),
    .bready_i    (bready),
    .araddr_i    (araddr),
    .arvalid_i   (arvalid),
    .arready_o   (arready),
    .rdata_o     (rdata),
    .rresp_o     (rresp),
    .rvalid_o    (rvalid),
    .rready_i    (rready),
    .dom_switch_o(dom_switch),
    .dom_iso_o   (dom_iso),
    .dom_rst_n_o (dom_rst_n),
    .dom_ret_o   (dom_ret),
    .irq_o       (irq)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Status layout: is_on 7:0, busy 15:8, err 23:16
  function automatic logic [31:0] exp_status(input logic [7:0] is_on,
                                             input logic [7:0] busy,
                                             input logic [7:0] err);
    return {8'h00, err, busy, is_on};
  endfunction

  function automatic logic [31:0] pin_word(input logic [3:0] sw,
                                           input logic [3:0] iso,
                                           input logic [3:0] rst_n,
                                           input logic [3:0] ret);
    return {16'h0000, sw, iso, rst_n, ret};
  endfunction

  task automatic add_step(input string name, input op_e op, input logic [7:0] addr,
                          input logic [31:0] data, input logic [31:0] exp,
                          input logic [1:0] resp);
    steps[n_steps].name = name;
    steps[n_steps].op   = op;
    steps[n_steps].addr = addr;
    steps[n_steps].data = data;
    steps[n_steps].exp  = exp;
    steps[n_steps].resp = resp;
    n_steps++;
  endtask

  task automatic fill_table();
    add_step("reset status", OP_READ, REG_STATUS, 0, exp_status(0, 0, 0), RESP_OKAY);
    add_step("reset irq low", OP_IRQ, 0, 0, 0, RESP_OKAY);
    add_step("reset pins", OP_PINS, 0, 0, pin_word(4'h0, 4'hf, 4'h0, 4'h0), RESP_OKAY);
    add_step("irq enable", OP_WRITE, REG_IRQ_ENABLE, 32'hf, 0, RESP_OKAY);
    add_step("power on 0 1", OP_WRITE, REG_POWER_ON, 32'h3, 0, RESP_OKAY);
    add_step("power on irq", OP_IRQ, 0, 0, 1, RESP_OKAY);
    add_step("pending after on", OP_READ, REG_IRQ_PENDING, 0, 32'h3, RESP_OKAY);
    add_step("status after on", OP_READ, REG_STATUS, 0, exp_status(8'h3, 0, 0), RESP_OKAY);
    add_step("pins after on", OP_PINS, 0, 0, pin_word(4'h3, 4'hc, 4'h3, 4'h0), RESP_OKAY);
    add_step("clear pending", OP_WRITE, REG_IRQ_PENDING, 32'hf, 0, RESP_OKAY);
    add_step("irq cleared", OP_IRQ, 0, 0, 0, RESP_OKAY);
    add_step("pending cleared", OP_READ, REG_IRQ_PENDING, 0, 0, RESP_OKAY);
    add_step("retention 0", OP_WRITE, REG_RETENTIVE, 32'h1, 0, RESP_OKAY);
    add_step("power off 0", OP_WRITE, REG_POWER_OFF, 32'h1, 0, RESP_OKAY);
    add_step("power off irq", OP_IRQ, 0, 0, 1, RESP_OKAY);
    add_step("status after off", OP_READ, REG_STATUS, 0, exp_status(8'h2, 0, 0), RESP_OKAY);
    add_step("pins after off", OP_PINS, 0, 0, pin_word(4'h2, 4'hd, 4'h2, 4'h1), RESP_OKAY);
    add_step("clear off pending", OP_WRITE, REG_IRQ_PENDING, 32'h1, 0, RESP_OKAY);
    add_step("irq low after off", OP_IRQ, 0, 0, 0, RESP_OKAY);
    add_step("stuck ack 3", OP_STUCK, 0, 32'h1, 0, RESP_OKAY);
    add_step("power on 3", OP_WRITE, REG_POWER_ON, 32'h8, 0, RESP_OKAY);
    add_step("timeout irq", OP_IRQ, 0, 0, 1, RESP_OKAY);
    add_step("status after timeout", OP_READ, REG_STATUS, 0, exp_status(8'h2, 0, 8'h8),
             RESP_OKAY);
    add_step("pending after timeout", OP_READ, REG_IRQ_PENDING, 0, 32'h8, RESP_OKAY);
    add_step("pins after timeout", OP_PINS, 0, 0, pin_word(4'h2, 4'hd, 4'h2, 4'h1), RESP_OKAY);
    add_step("write unmapped", OP_WRITE, 8'h20, 32'hf, 0, RESP_SLVERR);
    add_step("read unmapped", OP_READ, 8'h20, 0, 0, RESP_SLVERR);
    add_step("write status", OP_WRITE, REG_STATUS, 32'hffff_ffff, 0, RESP_SLVERR);
    add_step("retention kept", OP_READ, REG_RETENTIVE, 0, 32'h1, RESP_OKAY);
    add_step("irq enable kept", OP_READ, REG_IRQ_ENABLE, 0, 32'hf, RESP_OKAY);
    add_step("status kept", OP_READ, REG_STATUS, 0, exp_status(8'h2, 0, 8'h8), RESP_OKAY);
  endtask

  // Outputs are sampled on the falling edge, inputs change on the rising edge
  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp, output bit ok);
    int n;
    resp = RESP_OKAY;
    @(posedge clk_i);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= '1;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!(awready && wready) && n < AXI_WAIT);
    ok = awready && wready;
    @(posedge clk_i);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    if (ok) begin
      n = 0;
      do begin
        @(negedge clk_i);
        n++;
      end while (!bvalid && n < AXI_WAIT);
      ok   = bvalid;
      resp = bresp;
      @(posedge clk_i);
    end
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp, output bit ok);
    int n;
    data = '0;
    resp = RESP_OKAY;
    @(posedge clk_i);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!arready && n < AXI_WAIT);
    ok = arready;
    @(posedge clk_i);
    arvalid <= 1'b0;
    if (ok) begin
      n = 0;
      do begin
        @(negedge clk_i);
        n++;
      end while (!rvalid && n < AXI_WAIT);
      ok   = rvalid;
      data = rdata;
      resp = rresp;
      @(posedge clk_i);
    end
    rready <= 1'b0;
  endtask

  task automatic wait_irq(input logic level, output bit ok);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (irq !== level && n < IRQ_WAIT);
    ok = (irq === level);
  endtask

  task automatic run_step(input step_t s);
    logic [31:0] got;
    logic [1:0]  resp;
    bit          ok;
    got  = s.exp;
    resp = s.resp;
    ok   = 1'b1;
    case (s.op)
      OP_WRITE: axi_write(s.addr, s.data, resp, ok);
      OP_READ:  axi_read(s.addr, got, resp, ok);
      OP_IRQ:   wait_irq(s.exp[0], ok);
      OP_PINS: begin
        @(negedge clk_i);
        got = {16'h0000, dom_switch, dom_iso, dom_rst_n, dom_ret};
      end
      default: begin
        // Harness setting only, nothing to compare
        @(posedge clk_i);
        stuck <= s.data[0];
        return;
      end
    endcase
    if (!ok) begin
      $display("%s: the DUT did not respond before the timeout", s.name);
      n_fail++;
    end else if (got !== s.exp) begin
      $display("Error %s: expected %h, actual %h", s.name, s.exp, got);
      n_fail++;
    end else if (resp !== s.resp) begin
      $display("Error %s response: expected %0d, actual %0d", s.name, s.resp, resp);
      n_fail++;
    end else begin
      $display("ok    %s", s.name);
      n_pass++;
    end
  endtask

  initial begin
    rst_n_i = 1'b0;
    stuck   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    n_steps = 0;
    n_pass  = 0;
    n_fail  = 0;
    fill_table();
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    for (int i = 0; i < n_steps; i++) begin
      run_step(steps[i]);
    end
    $display("%0d tests, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: pwr_ctrl_top.f
verilog/pwr_pkg.sv
verilog/pwr_dom_if.sv
verilog/pwr_axil_regs.sv
verilog/pwr_domain_seq.sv
verilog/pwr_status_agg.sv
verilog/pwr_ctrl_top.sv
verif/pwr_testharness.sv
verif/tb_pwr_ctrl.sv

// File: Makefile
VERILATOR  = verilator
TB_TOP     = tb_pwr_ctrl
RTL_TOP    = pwr_ctrl_top
FILELIST   = pwr_ctrl_top.f
FLAGS      = --binary --timing --timescale 1ns/1ns -j 0
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ns
OBJ_DIR    = obj_dir
PASS_MSG   = Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
